// File: verilog/u1_core_pkg.sv
package u1_core_pkg;

   // bus geometry
   localparam int WB_DW  = 16;
   localparam int WB_AW  = 11;
   localparam int SLOT_W = 4;    // adr[10:7]

   localparam logic [SLOT_W-1:0] SLOT_MISC     = 4'd0;
   localparam logic [SLOT_W-1:0] SLOT_SETTINGS = 4'd5;

   // slot 0 byte offsets
   localparam logic [6:0] REG_LEDS      = 7'd0;
   localparam logic [6:0] REG_CGEN_CTRL = 7'd4;
   localparam logic [6:0] REG_CGEN_ST   = 7'd6;
   localparam logic [6:0] REG_TEST      = 7'd8;

   localparam logic [WB_DW-1:0] MISC_DEFAULT_RD = 16'hBEEF;

   // settings bus
   localparam int SET_AW = 8;
   localparam int SET_DW = 32;

   localparam logic [SET_AW-1:0] SR_TIME_SECS  = 8'd28;
   localparam logic [SET_AW-1:0] SR_TIME_TICKS = 8'd29;
   localparam logic [SET_AW-1:0] SR_TIME_IMM   = 8'd30;

   localparam logic [31:0] TICKS_PER_SEC = 32'd64000000;

   // tone path
   localparam int PH_W          = 24;   // full turn is 2**PH_W
   localparam int CORDIC_STAGES = 20;
   localparam int DAC_W         = 14;

   localparam logic signed [PH_W-1:0] TONE_AMPL = 24'sd2500000;

   //////////////////////////////////////////////////
   // bundles
   //////////////////////////////////////////////////

   typedef struct packed {
      logic [WB_AW-1:0] adr;
      logic [WB_DW-1:0] dat;
      logic             we;
      logic             cyc;
      logic             stb;
   } wb_req_t;

   typedef struct packed {
      logic [WB_DW-1:0] dat;
      logic             ack;
   } wb_rsp_t;

   typedef struct packed {
      logic              stb;
      logic [SET_AW-1:0] addr;
      logic [SET_DW-1:0] data;
   } set_bus_t;

   typedef struct packed {
      logic signed [PH_W-1:0] x;
      logic signed [PH_W-1:0] y;
      logic signed [PH_W-1:0] z;
   } cordic_sample_t;

   typedef struct packed {
      logic [31:0] seconds;
      logic [31:0] ticks;
   } vita_time_t;

   // atan(2**-i) scaled so that 2**PH_W is one turn
   function automatic logic signed [PH_W-1:0] cordic_atan(input int i);
      logic signed [PH_W-1:0] a;
      case (i)
         0:       a = 24'sd2097152;   // 45 deg
         1:       a = 24'sd1238021;
         2:       a = 24'sd654136;
         3:       a = 24'sd332050;
         4:       a = 24'sd166669;
         5:       a = 24'sd83416;
         6:       a = 24'sd41718;
         7:       a = 24'sd20860;
         8:       a = 24'sd10430;
         9:       a = 24'sd5215;
         10:      a = 24'sd2608;
         11:      a = 24'sd1304;
         12:      a = 24'sd652;
         13:      a = 24'sd326;
         14:      a = 24'sd163;
         15:      a = 24'sd81;
         16:      a = 24'sd41;
         17:      a = 24'sd20;
         18:      a = 24'sd10;
         19:      a = 24'sd5;
         20:      a = 24'sd3;
         default: a = 24'sd1;
      endcase
      return a;
   endfunction

endpackage

// File: verilog/wb_decoder.sv
`timescale 1ns/1ps

module wb_decoder
(
   input  u1_core_pkg::wb_req_t wb_req_i,
   output u1_core_pkg::wb_rsp_t wb_rsp_o,

   output u1_core_pkg::wb_req_t misc_req_o,
   input  u1_core_pkg::wb_rsp_t misc_rsp_i,

   output u1_core_pkg::wb_req_t set_req_o,
   input  u1_core_pkg::wb_rsp_t set_rsp_i
);

   import u1_core_pkg::*;

   logic [SLOT_W-1:0] slot;
   logic              hit_misc;
   logic              hit_set;

   assign slot     = wb_req_i.adr[WB_AW-1 -: SLOT_W];
   assign hit_misc = (slot == SLOT_MISC);
   assign hit_set  = (slot == SLOT_SETTINGS);

   // same request to both slaves, only the addressed one sees stb
   always_comb
   begin
      misc_req_o     = wb_req_i;
      misc_req_o.stb = wb_req_i.stb & hit_misc;
      set_req_o      = wb_req_i;
      set_req_o.stb  = wb_req_i.stb & hit_set;
   end

   // read data and ack back from the addressed slave
   always_comb
   begin
      wb_rsp_o = '0;   // other slots never ack
      if (hit_misc)
      begin
         wb_rsp_o = misc_rsp_i;
      end
      else if (hit_set)
      begin
         wb_rsp_o = set_rsp_i;
      end
   end

endmodule

// File: verilog/misc_regs.sv
`timescale 1ns/1ps

module misc_regs
(
   input  logic                            wb_clk,
   input  logic                            wb_rst,
   input  u1_core_pkg::wb_req_t            req_i,
   output u1_core_pkg::wb_rsp_t            rsp_o,
   input  logic                            cgen_st_status_i,
   input  logic                            cgen_st_ld_i,
   input  logic                            cgen_st_refmon_i,
   output logic [2:0]                      debug_led_o,
   output logic                            cgen_sync_b_o,
   output logic                            cgen_ref_sel_o,
   output logic [u1_core_pkg::WB_DW-1:0]   tone_freq_o
);

   import u1_core_pkg::*;

   logic [WB_DW-1:0] reg_leds;
   logic [WB_DW-1:0] reg_cgen_ctrl;
   logic [WB_DW-1:0] reg_test;
   logic [6:0]       offs;
   logic             access;

   assign offs   = req_i.adr[6:0];
   assign access = req_i.cyc & req_i.stb;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds      <= '0;
         reg_cgen_ctrl <= 16'd3;   // sync_b and ref_sel high out of reset
         reg_test      <= '0;
      end
      else if (access && req_i.we)
      begin
         case (offs)
            REG_LEDS:      reg_leds      <= req_i.dat;
            REG_CGEN_CTRL: reg_cgen_ctrl <= req_i.dat;
            REG_TEST:      reg_test      <= req_i.dat;
            default:       ;
         endcase
      end
   end

   // board wiring swaps leds 0 and 1
   assign debug_led_o    = {reg_leds[2], reg_leds[0], reg_leds[1]};
   assign cgen_sync_b_o  = reg_cgen_ctrl[1];
   assign cgen_ref_sel_o = reg_cgen_ctrl[0];
   assign tone_freq_o    = reg_test;

   always_comb
   begin
      case (offs)
         REG_LEDS:      rsp_o.dat = reg_leds;
         REG_CGEN_CTRL: rsp_o.dat = reg_cgen_ctrl;
         REG_CGEN_ST:   rsp_o.dat = {13'd0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         REG_TEST:      rsp_o.dat = reg_test;
         default:       rsp_o.dat = MISC_DEFAULT_RD;
      endcase
      rsp_o.ack = access;   // single cycle, no wait states
   end

endmodule

// File: verilog/settings_bus_16le.sv
`timescale 1ns/1ps

module settings_bus_16le
(
   input  logic                  wb_clk,
   input  logic                  wb_rst,
   input  u1_core_pkg::wb_req_t  req_i,
   output u1_core_pkg::wb_rsp_t  rsp_o,
   output u1_core_pkg::set_bus_t set_o
);

   import u1_core_pkg::*;

   logic [WB_DW-1:0]  low_half;
   logic              set_stb;
   logic [SET_AW-1:0] set_addr;
   logic [SET_DW-1:0] set_data;
   logic              wr;

   assign wr = req_i.cyc & req_i.stb & req_i.we;

   // strobe is the only control state here
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         set_stb <= 1'b0;
      else
         set_stb <= wr & req_i.adr[1];
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr && !req_i.adr[1])
      begin
         low_half <= req_i.dat;   // wait for the high half
      end
      if (wr && req_i.adr[1])
      begin
         set_addr <= {3'd0, req_i.adr[6:2]};   // 32 regs of 32 bits
         set_data <= {req_i.dat, low_half};
      end
   end

   assign set_o = '{stb: set_stb, addr: set_addr, data: set_data};
   assign rsp_o = '{dat: '0, ack: req_i.cyc & req_i.stb};

endmodule

// File: verilog/time_64bit.sv
`timescale 1ns/1ps

module time_64bit
#(
   parameter logic [31:0] ticks_per_sec = u1_core_pkg::TICKS_PER_SEC
)
(
   input  logic                    wb_clk,
   input  logic                    wb_rst,
   input  u1_core_pkg::set_bus_t   set_i,
   input  logic                    pps_i,
   output u1_core_pkg::vita_time_t vita_time_o
);

   import u1_core_pkg::*;

   vita_time_t  now;
   logic [31:0] pend_secs;
   logic [31:0] pend_ticks;
   logic        armed;
   logic [2:0]  pps_sr;   // two sync flops plus one for the edge
   logic        pps_edge;
   logic        imm_cmd;
   logic        load_now;
   logic        load_pps;

   assign imm_cmd  = set_i.stb && (set_i.addr == SR_TIME_IMM);
   assign load_now = imm_cmd && set_i.data[0];
   assign pps_edge = pps_sr[1] & ~pps_sr[2];
   assign load_pps = armed & pps_edge;

   // pending values from the settings bus
   always_ff @(posedge wb_clk)
   begin
      if (set_i.stb && set_i.addr == SR_TIME_SECS)
         pend_secs <= set_i.data;
      if (set_i.stb && set_i.addr == SR_TIME_TICKS)
         pend_ticks <= set_i.data;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         now    <= '0;
         armed  <= 1'b0;
         pps_sr <= '0;
      end
      else
      begin
         pps_sr <= {pps_sr[1:0], pps_i};
         if (imm_cmd)
            armed <= ~set_i.data[0];   // bit 0 clear means wait for pps
         else if (load_pps)
            armed <= 1'b0;

         if (load_now || load_pps)
         begin
            now.seconds <= pend_secs;
            now.ticks   <= pend_ticks;
         end
         else if (now.ticks == ticks_per_sec - 32'd1)
         begin
            now.ticks   <= '0;
            now.seconds <= now.seconds + 32'd1;
         end
         else
            now.ticks <= now.ticks + 32'd1;
      end
   end

   assign vita_time_o = now;

endmodule

// File: verilog/cordic_stage.sv
`timescale 1ns/1ps

module cordic_stage
#(
   parameter int shift = 0
)
(
   input  logic                        wb_clk,
   input  u1_core_pkg::cordic_sample_t sample_i,
   output u1_core_pkg::cordic_sample_t sample_o
);

   import u1_core_pkg::*;

   localparam logic signed [PH_W-1:0] ATAN = cordic_atan(shift);

   logic signed [PH_W-1:0] x_sh;
   logic signed [PH_W-1:0] y_sh;

   assign x_sh = sample_i.x >>> shift;
   assign y_sh = sample_i.y >>> shift;

   // drive z toward zero, one micro-rotation per clock
   always_ff @(posedge wb_clk)
   begin
      if (sample_i.z[PH_W-1])   // negative angle left, turn clockwise
      begin
         sample_o.x <= sample_i.x + y_sh;
         sample_o.y <= sample_i.y - x_sh;
         sample_o.z <= sample_i.z + ATAN;
      end
      else
      begin
         sample_o.x <= sample_i.x - y_sh;
         sample_o.y <= sample_i.y + x_sh;
         sample_o.z <= sample_i.z - ATAN;
      end
   end

endmodule

// File: verilog/tone_gen.sv
`timescale 1ns/1ps

module tone_gen
(
   input  logic                          wb_clk,
   input  logic                          wb_rst,
   input  logic [u1_core_pkg::WB_DW-1:0] tone_freq_i,
   output logic [u1_core_pkg::DAC_W-1:0] tx_i_o,
   output logic [u1_core_pkg::DAC_W-1:0] tx_q_o
);

   import u1_core_pkg::*;

   logic [PH_W-1:0] phase;
   cordic_sample_t  chain [0:CORDIC_STAGES];

   //////////////////////////////////////////////////
   // phase accumulator
   //////////////////////////////////////////////////
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         phase <= '0;
      else
         phase <= phase + {tone_freq_i, {(PH_W-WB_DW){1'b0}}};
   end

   // quarter turn toward the right half-plane, z lands in +-90 deg
   always_ff @(posedge wb_clk)
   begin
      case (phase[PH_W-1 -: 2])
         2'b01:   chain[0] <= '{x: '0, y: TONE_AMPL, z: '0};
         2'b10:   chain[0] <= '{x: '0, y: -TONE_AMPL, z: '0};
         default: chain[0] <= '{x: TONE_AMPL, y: '0, z: '0};
      endcase
      chain[0].z <= {phase[PH_W-1], phase[PH_W-1], phase[PH_W-3:0]};   // minus the quarter turn
   end

   //////////////////////////////////////////////////
   // rotation chain
   //////////////////////////////////////////////////
   for (genvar i = 0; i < CORDIC_STAGES; i++)
   begin : g_stage
      cordic_stage #(.shift(i)) i_cordic_stage
      (
         .wb_clk   (wb_clk),
         .sample_i (chain[i]),
         .sample_o (chain[i+1])
      );
   end

   assign tx_i_o = chain[CORDIC_STAGES].x[PH_W-1 -: DAC_W];
   assign tx_q_o = chain[CORDIC_STAGES].y[PH_W-1 -: DAC_W];

endmodule

// File: verilog/u1_core.sv
`timescale 1ns/1ps

module u1_core
(
   input  logic                          wb_clk,
   input  logic                          wb_rst,
   input  u1_core_pkg::wb_req_t          wb_req_i,
   output u1_core_pkg::wb_rsp_t          wb_rsp_o,
   input  logic                          cgen_st_status_i,
   input  logic                          cgen_st_ld_i,
   input  logic                          cgen_st_refmon_i,
   input  logic                          pps_i,
   output logic [2:0]                    debug_led_o,
   output logic                          cgen_sync_b_o,
   output logic                          cgen_ref_sel_o,
   output logic [u1_core_pkg::DAC_W-1:0] tx_i_o,
   output logic [u1_core_pkg::DAC_W-1:0] tx_q_o,
   output u1_core_pkg::vita_time_t       vita_time_o
);

   import u1_core_pkg::*;

   wb_req_t          misc_req, set_req;
   wb_rsp_t          misc_rsp, set_rsp;
   set_bus_t         set_bus;
   logic [WB_DW-1:0] tone_freq;

   //////////////////////////////////////////////////
   // register side
   //////////////////////////////////////////////////
   wb_decoder i_wb_decoder
   (
      .wb_req_i   (wb_req_i),  .wb_rsp_o  (wb_rsp_o),
      .misc_req_o (misc_req),  .misc_rsp_i(misc_rsp),
      .set_req_o  (set_req),   .set_rsp_i (set_rsp)
   );

   misc_regs i_misc_regs   // slot 0
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .req_i(misc_req), .rsp_o(misc_rsp),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i), .debug_led_o(debug_led_o),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o),
      .tone_freq_o(tone_freq)
   );

   settings_bus_16le i_settings_bus   // slot 5
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .req_i(set_req), .rsp_o(set_rsp), .set_o(set_bus)
   );

   time_64bit #(.ticks_per_sec(TICKS_PER_SEC)) i_time_64bit
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .set_i(set_bus), .pps_i(pps_i),
      .vita_time_o(vita_time_o)
   );

   // test tone toward the dac
   tone_gen i_tone_gen
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .tone_freq_i(tone_freq),
      .tx_i_o(tx_i_o), .tx_q_o(tx_q_o)
   );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
(
   output logic wb_clk_o,
   output logic wb_rst_o
);

   localparam int HALF_NS    = 50;   // 100 ns period
   localparam int RST_CYCLES = 2;

   initial
   begin
      wb_clk_o = 1'b0;
      forever #(HALF_NS) wb_clk_o = ~wb_clk_o;
   end

   initial
   begin
      wb_rst_o = 1'b1;
      repeat (RST_CYCLES) @(posedge wb_clk_o);
      #1 wb_rst_o = 1'b0;   // released just after the edge
   end

endmodule

// File: testbench/u1_core_properties.sv
`timescale 1ns/1ps

module u1_core_properties
(
   input logic                    wb_clk,
   input logic                    wb_rst,
   input u1_core_pkg::wb_req_t    req_i,
   input u1_core_pkg::wb_rsp_t    rsp_i,
   input logic [2:0]              debug_led_i,
   input logic                    cgen_sync_b_i,
   input logic                    cgen_ref_sel_i,
   input u1_core_pkg::vita_time_t vita_time_i
);

   import u1_core_pkg::*;

   logic [SLOT_W-1:0] slot;
   logic              access;
   logic              live_slot;

   assign slot      = req_i.adr[WB_AW-1 -: SLOT_W];
   assign access    = req_i.cyc & req_i.stb;
   assign live_slot = (slot == SLOT_MISC) || (slot == SLOT_SETTINGS);

   //////////////////////////////////////////////////
   // bus ack
   //////////////////////////////////////////////////
   ack_needs_request: assert property (@(posedge wb_clk) disable iff (wb_rst)
      rsp_i.ack |-> access)
      else $error("ack seen without an active bus cycle");

   live_slot_acks: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (access && live_slot) |-> rsp_i.ack)   // combinational, same cycle
      else $error("access to slot %0d was not acked", slot);

   // first edge out of reset still shows the reset values
   reset_values: assert property (@(posedge wb_clk)
      $fell(wb_rst) |-> (debug_led_i == 3'd0 && cgen_sync_b_i && cgen_ref_sel_i
                         && vita_time_i == '0))
      else $error("outputs not at reset values after reset");

   ticks_in_range: assert property (@(posedge wb_clk) disable iff (wb_rst)
      vita_time_i.ticks < TICKS_PER_SEC)
      else $error("ticks out of range: %0d", vita_time_i.ticks);

endmodule

// File: testbench/u1_core_tb.sv
`timescale 1ns/1ps

module u1_core_tb;

   import u1_core_pkg::*;

   localparam int ACK_LIMIT = 16;   // cycles to wait for a bus ack

   logic             wb_clk;
   logic             wb_rst;
   wb_req_t          wb_req;
   wb_rsp_t          wb_rsp;
   logic             cgen_st_status;
   logic             cgen_st_ld;
   logic             cgen_st_refmon;
   logic             pps;
   logic [2:0]       debug_led;
   logic             cgen_sync_b;
   logic             cgen_ref_sel;
   logic [DAC_W-1:0] tx_i;
   logic [DAC_W-1:0] tx_q;
   vita_time_t       vita_time;

   // test table, one entry per file line
   string       op_q[$];
   string       name_q[$];
   logic [31:0] a_q[$];
   logic [31:0] b_q[$];
   logic [31:0] exp_q[$];

   int cycles      = 0;
   int cycle_limit = 0;   // set once the table is read

   tb_clock i_tb_clock (.wb_clk_o(wb_clk), .wb_rst_o(wb_rst));

   u1_core i_u1_core
   (
      .wb_clk           (wb_clk),
      .wb_rst           (wb_rst),
      .wb_req_i         (wb_req),
      .wb_rsp_o         (wb_rsp),
      .cgen_st_status_i (cgen_st_status),
      .cgen_st_ld_i     (cgen_st_ld),
      .cgen_st_refmon_i (cgen_st_refmon),
      .pps_i            (pps),
      .debug_led_o      (debug_led),
      .cgen_sync_b_o    (cgen_sync_b),
      .cgen_ref_sel_o   (cgen_ref_sel),
      .tx_i_o           (tx_i),
      .tx_q_o           (tx_q),
      .vita_time_o      (vita_time)
   );

   bind u1_core u1_core_properties i_u1_core_properties
   (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .req_i(wb_req_i), .rsp_i(wb_rsp_o),
      .debug_led_i(debug_led_o), .cgen_sync_b_i(cgen_sync_b_o),
      .cgen_ref_sel_i(cgen_ref_sel_o), .vita_time_i(vita_time_o)
   );

   //////////////////////////////////////////////////
   // reporting
   //////////////////////////////////////////////////
   task automatic fail_run(input string msg);
      $display("error: %s", msg);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input longint expected,
                              input longint actual, input int tol);
      longint diff;
      diff = actual - expected;
      if (diff < 0)
         diff = -diff;
      if (diff > longint'(tol))
      begin
         $display("** Error: %s: expected %0d, actual %0d", name, expected, actual);
         $display("TEST FAILED");
         $fatal(1);
      end
   endtask

   always @(posedge wb_clk)
   begin
      cycles <= cycles + 1;
      if (cycle_limit != 0 && cycles >= cycle_limit)
      begin
         $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
         $display("TEST FAILED");
         $fatal(1);
      end
   end

   //////////////////////////////////////////////////
   // bus and settings access
   //////////////////////////////////////////////////
   task automatic bus_access(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] dat,
                             input logic we, output logic [WB_DW-1:0] rdata);
      int waited;
      waited = 0;
      @(posedge wb_clk);
      #1;
      wb_req.adr = adr;
      wb_req.dat = dat;
      wb_req.we  = we;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      @(negedge wb_clk);
      while (!wb_rsp.ack)
      begin
         waited++;
         if (waited > ACK_LIMIT)
            fail_run($sformatf("no ack for bus address %h", adr));
         else
            @(negedge wb_clk);
      end
      rdata = wb_rsp.dat;   // read data valid with the ack
      @(posedge wb_clk);
      #1;
      wb_req = '0;
   endtask

   // slot in 10..7, register in 6..2, halfword in 1
   function automatic logic [WB_AW-1:0] set_adr(input logic [SET_AW-1:0] num,
                                                input logic high);
      return {SLOT_SETTINGS, num[4:0], high, 1'b0};
   endfunction

   task automatic set_write(input logic [SET_AW-1:0] num, input logic [31:0] data);
      logic [WB_DW-1:0] unused_rd;
      bus_access(set_adr(num, 1'b0), data[15:0], 1'b1, unused_rd);
      bus_access(set_adr(num, 1'b1), data[31:16], 1'b1, unused_rd);   // fires the strobe
   endtask

   task automatic load_time(input logic [31:0] secs, input logic [31:0] ticks,
                            input logic imm);
      set_write(SR_TIME_SECS, secs);
      set_write(SR_TIME_TICKS, ticks);
      set_write(SR_TIME_IMM, {31'd0, imm});
   endtask

   task automatic wait_seconds(input logic [31:0] want, input int limit);
      int waited;
      waited = 0;
      @(negedge wb_clk);
      while (vita_time.seconds != want && waited < limit)
      begin
         waited++;
         @(negedge wb_clk);
      end
   endtask

   task automatic hold_seconds(input string name, input logic [31:0] held, input int n);
      repeat (n)
      begin
         @(negedge wb_clk);
         check_value(name, longint'(held), longint'(vita_time.seconds), 0);
      end
   endtask

   //////////////////////////////////////////////////
   // test tone
   //////////////////////////////////////////////////
   task automatic run_tone(input string name, input logic [WB_AW-1:0] adr,
                           input logic [WB_DW-1:0] freq, input logic [31:0] ampl);
      logic [WB_DW-1:0] unused_rd;
      longint           i_val;
      longint           q_val;
      longint           prev_i;
      longint           prev_q;
      longint           want;
      int               changes;
      bus_access(adr, freq, 1'b1, unused_rd);
      want    = longint'(ampl) * longint'(ampl);
      prev_i  = 0;
      prev_q  = 0;
      changes = 0;
      if (freq == '0)
      begin
         repeat (30) @(posedge wb_clk);   // past the pipeline latency
         @(negedge wb_clk);
         check_value($sformatf("%s_i", name), longint'(ampl), longint'($signed(tx_i)), 8);
         check_value($sformatf("%s_q", name), longint'(0), longint'($signed(tx_q)), 8);
      end
      else
      begin
         repeat (200)
         begin
            @(negedge wb_clk);
            i_val = longint'($signed(tx_i));
            q_val = longint'($signed(tx_q));
            check_value($sformatf("%s_mag", name), want, i_val * i_val + q_val * q_val,
                        int'(want * 3 / 100));   // 3 percent of full scale
            if (i_val != prev_i || q_val != prev_q)
               changes++;
            prev_i = i_val;
            prev_q = q_val;
         end
         check_value($sformatf("%s_changes", name), longint'(1), longint'(changes > 1), 0);
      end
   endtask

   //////////////////////////////////////////////////
   // one line of the table
   //////////////////////////////////////////////////
   task automatic run_test(input int k);
      logic [WB_DW-1:0] rdata;
      logic [31:0]      held;
      logic [31:0]      a;
      logic [31:0]      b;
      logic [31:0]      e;
      int               delay;
      string            name;
      name = name_q[k];
      a    = a_q[k];
      b    = b_q[k];
      e    = exp_q[k];
      if (op_q[k] == "write")
         bus_access(a[WB_AW-1:0], b[WB_DW-1:0], 1'b1, rdata);
      else if (op_q[k] == "read")
      begin
         bus_access(a[WB_AW-1:0], '0, 1'b0, rdata);
         check_value(name, longint'(e), longint'(rdata), 0);
      end
      else if (op_q[k] == "pins")
      begin
         @(negedge wb_clk);
         check_value(name, longint'(e), longint'({cgen_sync_b, cgen_ref_sel, debug_led}), 0);
      end
      else if (op_q[k] == "status")
      begin
         @(posedge wb_clk);
         #1;
         {cgen_st_status, cgen_st_ld, cgen_st_refmon} = b[2:0];
      end
      else if (op_q[k] == "time_imm")
      begin
         load_time(a, b, 1'b1);
         wait_seconds(e, 10);
         check_value(name, longint'(e), longint'(vita_time.seconds), 0);
         if (e == a)
            check_value($sformatf("%s_ticks", name), longint'(b),
                        longint'(vita_time.ticks), 10);
         else   // wrapped into the next second
            check_value($sformatf("%s_ticks", name), longint'(0),
                        longint'(vita_time.ticks), 10);
      end
      else if (op_q[k] == "time_pps")
      begin
         @(negedge wb_clk);
         held = vita_time.seconds;
         load_time(a, b, 1'b0);
         hold_seconds(name, held, 20);   // armed only, no load yet
      end
      else if (op_q[k] == "pps")
      begin
         @(negedge wb_clk);
         held  = vita_time.seconds;
         delay = 5 + int'($urandom % 16);
         hold_seconds(name, held, delay);
         @(posedge wb_clk);
         #1;
         pps = 1'b1;
         wait_seconds(e, 5);
         check_value(name, longint'(e), longint'(vita_time.seconds), 0);
         @(posedge wb_clk);
         #1;
         pps = 1'b0;
      end
      else if (op_q[k] == "tone")
         run_tone(name, a[WB_AW-1:0], b[WB_DW-1:0], e);
      else
         fail_run($sformatf("unknown operation %s in line %s", op_q[k], name));
   endtask

   initial
   begin
      int          fd;
      int          cnt;
      string       line;
      string       op;
      string       name;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] e;

      wb_req         = '0;
      pps            = 1'b0;
      cgen_st_status = 1'b0;
      cgen_st_ld     = 1'b0;
      cgen_st_refmon = 1'b0;
      void'($urandom(93));

      fd = $fopen("testbench/u1_core_tests.txt", "r");
      if (fd == 0)
         fail_run("cannot open testbench/u1_core_tests.txt");
      while (!$feof(fd))
      begin
         line = "";
         cnt  = $fgets(line, fd);
         if (line.len() > 1 && line.getc(0) != "#")
         begin
            cnt = $sscanf(line, "%s %s %h %h %h", op, name, a, b, e);
            if (cnt != 5)
               fail_run($sformatf("bad line in tests file: %s", line));
            else
            begin
               op_q.push_back(op);
               name_q.push_back(name);
               a_q.push_back(a);
               b_q.push_back(b);
               exp_q.push_back(e);
            end
         end
      end
      $fclose(fd);
      cycle_limit = 300 * op_q.size() + 2000;

      @(negedge wb_rst);
      for (int k = 0; k < op_q.size(); k++)
         run_test(k);

      $display("TEST OK");
      $finish;
   end

endmodule

// File: testbench/u1_core_tests.txt
# op  name  addr  data  expected, numbers in hex; time ops carry seconds in addr, ticks in data
# pins expects {cgen_sync_b, cgen_ref_sel, debug_led[2:0]}; tone expects the I amplitude
read      rst_cgen_ctrl     004       0000      0003
pins      rst_pins          000       0000      0018
tone      tone_dc           008       0000      0fb4
write     wr_leds           000       0007      0000
read      rd_leds           000       0000      0007
write     wr_cgen_ctrl      004       0002      0000
read      rd_cgen_ctrl      004       0000      0002
write     wr_test           008       a5c3      0000
read      rd_test           008       0000      a5c3
write     led_bit0          000       0001      0000
pins      led_bit0_pins     000       0000      0012
write     led_bit1          000       0002      0000
pins      led_bit1_pins     000       0000      0011
write     led_bit2          000       0004      0000
pins      led_bit2_pins     000       0000      0014
status    set_status        000       0005      0000
read      rd_cgen_st        006       0000      0005
read      rd_unmapped       00c       0000      beef
time_imm  imm_load          00001234  00000100  00001234
time_imm  tick_wrap         00000010  03d08ffb  00000011
time_pps  pps_arm           00000077  00000040  00000000
pps       pps_load          000       0000      00000077
tone      tone_run          008       1000      0fb4

// File: sources.f
verilog/u1_core_pkg.sv
verilog/wb_decoder.sv
verilog/misc_regs.sv
verilog/settings_bus_16le.sv
verilog/time_64bit.sv
verilog/cordic_stage.sv
verilog/tone_gen.sv
verilog/u1_core.sv
testbench/tb_clock.sv
testbench/u1_core_properties.sv
testbench/u1_core_tb.sv

// File: Makefile
TOP = u1_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
